// ==== list.f ====
design/core_out_pkg.sv
design/cpu_phase_gen.sv
design/video_edge_stage.sv
design/video_encode_stage.sv
design/core_glue_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// ==== Makefile ====
TOP = tb_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f list.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

// ==== testbench/tb_top.sv ====
////////////////////////////////////////////////////////////
// testbench top with clock, reset, stimulus and watchdog
// inputs change on the rising edge through non-blocking writes
// one seed drives every random choice
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_top;

	import core_out_pkg::*;

	localparam int PERIOD_NS = 40;
	localparam int RESET_CYCLES = 4;
	localparam int FREE_CYCLES = 64;           // c1 held low
	localparam int ALIGN_CYCLES = 200;         // random c1 edges
	localparam int RAM_CYCLES = 200;           // random ram_ctl
	localparam int ACTIVE_PIX = 16;
	localparam int BLANK_PIX = 8;
	localparam int LINES = 4;
	localparam int VS_PIX = 12;                // strobes per vsync burst
	localparam int FLUSH_PIX = 4;
	localparam int MAX_GAP = 4;                // worst case clocks per strobe
	localparam int END_CYCLES = 8;
	localparam int STROBES = LINES * (ACTIVE_PIX + BLANK_PIX) + 4 * VS_PIX + FLUSH_PIX;
	localparam int TEST_CYCLES = RESET_CYCLES + FREE_CYCLES + ALIGN_CYCLES + RAM_CYCLES
		+ STROBES * MAX_GAP + END_CYCLES;

	logic clk_114 = 1'b0;
	logic cpu_rst;
	logic c1;
	logic pix_en;
	logic cyc;
	logic cpu_ph1;
	logic cpu_ph2;
	logic ram_cs;
	ram_ctl_t ram_ctl;
	chip_video_t chip_video;
	scaler_video_t scaler_video;
	chip_video_t idle_v;                       // blanked with both syncs high
	int seed;
	int rnd;
	int error_count;
	int check_count;

	always #(PERIOD_NS / 2) clk_114 = ~clk_114;

	core_glue_top dut (
		.clk_114      (clk_114),
		.cpu_rst      (cpu_rst),
		.c1           (c1),
		.ram_ctl      (ram_ctl),
		.pix_en       (pix_en),
		.chip_video   (chip_video),
		.cyc          (cyc),
		.cpu_ph1      (cpu_ph1),
		.cpu_ph2      (cpu_ph2),
		.ram_cs       (ram_cs),
		.scaler_video (scaler_video)
	);

	tb_checker u_check (
		.clk_114      (clk_114),
		.cpu_rst      (cpu_rst),
		.c1           (c1),
		.ram_ctl      (ram_ctl),
		.pix_en       (pix_en),
		.chip_video   (chip_video),
		.cyc          (cyc),
		.cpu_ph1      (cpu_ph1),
		.cpu_ph2      (cpu_ph2),
		.ram_cs       (ram_cs),
		.scaler_video (scaler_video),
		.error_count  (error_count),
		.check_count  (check_count)
	);

	// random idle gap, then one strobe carrying v
	task automatic send_strobe(input chip_video_t v);
		int gap;
		gap = $random(seed) & (MAX_GAP - 1);
		repeat (gap) begin
			@(posedge clk_114);
			pix_en <= 1'b0;
		end
		@(posedge clk_114);
		pix_en <= 1'b1;
		chip_video <= v;
	endtask

	// active pixels, then blanking with a 3 strobe hs low
	task automatic send_line(input res_t res);
		chip_video_t v;
		v = '0;
		v.vs = 1'b1;
		v.res = res;
		for (int i = 0; i < ACTIVE_PIX + BLANK_PIX; i++) begin
			rnd = $random(seed);
			v.rgb = rnd[23:0];
			v.hblank = (i >= ACTIVE_PIX);
			v.hs = !(i >= ACTIVE_PIX + 2 && i < ACTIVE_PIX + 5);
			send_strobe(v);
		end
	endtask

	// vs drops in the middle of active video
	task automatic send_vsync(input logic lace, input logic field1);
		chip_video_t v;
		v = '0;
		v.hs = 1'b1;
		v.lace = lace;
		v.field1 = field1;
		for (int i = 0; i < VS_PIX; i++) begin
			rnd = $random(seed);
			v.rgb = rnd[23:0];
			v.res = rnd[25:24];
			v.vs = !(i >= 4 && i < 8);             // low for 4 strobes
			send_strobe(v);
		end
	endtask

	initial begin
		seed = 1313;
		idle_v = '0;
		idle_v.hs = 1'b1;
		idle_v.vs = 1'b1;
		idle_v.hblank = 1'b1;
		cpu_rst = 1'b0;
		c1 = 1'b0;
		pix_en = 1'b0;
		ram_ctl = '0;
		chip_video = idle_v;
		repeat (RESET_CYCLES) @(posedge clk_114);
		cpu_rst <= 1'b1;
		repeat (FREE_CYCLES) @(posedge clk_114);   // free running divider
		repeat (ALIGN_CYCLES) begin
			@(posedge clk_114);
			rnd = $random(seed);
			c1 <= (rnd[2:0] == 3'd0);              // short c1 pulses
		end
		@(posedge clk_114);
		c1 <= 1'b0;
		repeat (RAM_CYCLES) begin
			@(posedge clk_114);
			rnd = $random(seed);
			ram_ctl <= rnd[2:0];
		end
		for (int ln = 0; ln < LINES; ln++)
			send_line(res_t'(ln));
		for (int k = 0; k < 4; k++)
			send_vsync(k[1], k[0]);                // all lace/field1 pairs
		repeat (FLUSH_PIX) send_strobe(idle_v);
		@(posedge clk_114);
		pix_en <= 1'b0;
		repeat (END_CYCLES) @(posedge clk_114);
		@(posedge clk_114);                        // last compare done
		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	// watchdog sized from the test lengths
	initial begin
		#(TEST_CYCLES * PERIOD_NS + 20 * PERIOD_NS);
		$display("watchdog expired, stimulus did not finish in time");
		$display("checks %0d, errors %0d", check_count, error_count);
		$display("Testbench failed");
		$finish;
	end

endmodule

// ==== testbench/tb_checker.sv ====
////////////////////////////////////////////////////////////
// cycle model of the glue top, compared on every falling edge
// model steps on the rising edge with the same inputs as the dut
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_checker (
	input  logic                       clk_114,
	input  logic                       cpu_rst,
	input  logic                       c1,
	input  core_out_pkg::ram_ctl_t     ram_ctl,
	input  logic                       pix_en,
	input  core_out_pkg::chip_video_t  chip_video,
	input  logic                       cyc,
	input  logic                       cpu_ph1,
	input  logic                       cpu_ph2,
	input  logic                       ram_cs,
	input  core_out_pkg::scaler_video_t scaler_video,
	output int                         error_count,
	output int                         check_count
);

	import core_out_pkg::*;

	typedef struct packed {
		div_t div;
		logic c1d;
		logic cyc;
		logic ph1;
		logic ph2;
		logic ram_cs;
	} phase_state_t;

	phase_state_t phase_m;                     // phase generator model
	logic hs_prev_m;
	logic vs_prev_m;
	logic blank_prev_m;
	edge_flags_t flags_m;                      // stage 1 model
	scaler_video_t video_m;                    // stage 2 model
	logic model_valid = 1'b0;
	int errors = 0;
	int checks = 0;

	assign error_count = errors;
	assign check_count = checks;

	// one clock of the phase generator
	function automatic phase_state_t phase_step(input phase_state_t s, input logic c1_in,
		input ram_ctl_t ctl);
		phase_state_t n;
		logic [1:0] slot;
		n = s;
		slot = s.div[3:2];
		n.c1d = c1_in;
		n.div = (c1_in && !s.c1d) ? DIV_ALIGN : div_t'(s.div + 4'd1);
		n.cyc = (s.div[1:0] == 2'd0);
		if (s.div[1:0] == 2'd2) begin
			n.ph1 = (slot == PH1_SLOT);
			n.ph2 = (slot == PH2_SLOT);
		end
		n.ram_cs = ctl.ram_sel && !(ctl.ram_ready && s.cyc && ctl.cpu_type);
		return n;
	endfunction

	// scaler word from one set of edge flags
	function automatic scaler_video_t encode_video(input edge_flags_t f);
		scaler_video_t o;
		o = '0;
		o.hs = f.hs_fall;
		if (f.vs_fall) begin
			o.vs = 1'b1;
			o.rgb[LACE_BIT] = f.lace;
			o.rgb[FIELD_BIT] = f.lace_field;
		end else if (!f.blank) begin
			o.de = 1'b1;
			o.rgb = f.rgb;
		end else if (f.hblank_rise) begin
			o.rgb = rgb_t'(f.res) << RES_LSB;  // res word
		end
		return o;
	endfunction

	task automatic check_value(input string name, input logic [23:0] exp,
		input logic [23:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Mismatch %s expected %h actual %h at %0t", name, exp, act, $time);
		end
	endtask

	////////////////////////////////////////////////////////////
	// model update
	////////////////////////////////////////////////////////////

	always @(posedge clk_114) begin
		model_valid = 1'b1;
		if (!cpu_rst) begin
			phase_m = '0;
			hs_prev_m = 1'b1;
			vs_prev_m = 1'b1;
			blank_prev_m = 1'b0;
			flags_m = '0;
			video_m = '0;
		end else begin
			phase_m = phase_step(phase_m, c1, ram_ctl);
			if (pix_en) begin
				video_m = encode_video(flags_m);   // older flags first
				flags_m.hs_fall = hs_prev_m && !chip_video.hs;
				flags_m.vs_fall = vs_prev_m && !chip_video.vs;
				flags_m.hblank_rise = !blank_prev_m && chip_video.hblank;
				flags_m.blank = chip_video.hblank;
				flags_m.lace_field = chip_video.lace && chip_video.field1;
				flags_m.lace = chip_video.lace;
				flags_m.res = chip_video.res;
				flags_m.rgb = chip_video.rgb;
				hs_prev_m = chip_video.hs;
				vs_prev_m = chip_video.vs;
				blank_prev_m = chip_video.hblank;
			end
		end
	end

	// outputs are settled by the falling edge
	always @(negedge clk_114) begin
		if (model_valid) begin
			check_value("cyc", 24'(phase_m.cyc), 24'(cyc));
			check_value("cpu_ph1", 24'(phase_m.ph1), 24'(cpu_ph1));
			check_value("cpu_ph2", 24'(phase_m.ph2), 24'(cpu_ph2));
			check_value("ram_cs", 24'(phase_m.ram_cs), 24'(ram_cs));
			check_value("scaler_video.rgb", video_m.rgb, scaler_video.rgb);
			check_value("scaler_video.de", 24'(video_m.de), 24'(scaler_video.de));
			check_value("scaler_video.vs", 24'(video_m.vs), 24'(scaler_video.vs));
			check_value("scaler_video.hs", 24'(video_m.hs), 24'(scaler_video.hs));
		end
	end

endmodule

// ==== design/core_glue_top.sv ====
////////////////////////////////////////////////////////////
// glue top, phase generator beside a two stage video path
// all ports synchronous to clk_114, no back pressure
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module core_glue_top (
	input  logic                       clk_114,
	input  logic                       cpu_rst,      // sync, active low
	input  logic                       c1,
	input  core_out_pkg::ram_ctl_t     ram_ctl,
	input  logic                       pix_en,
	input  core_out_pkg::chip_video_t  chip_video,
	output logic                       cyc,
	output logic                       cpu_ph1,
	output logic                       cpu_ph2,
	output logic                       ram_cs,
	output core_out_pkg::scaler_video_t scaler_video
);

	import core_out_pkg::*;

	edge_flags_t edge_flags;                   // stage 1 to stage 2

	cpu_phase_gen u_phase (
		.clk_114 (clk_114),
		.cpu_rst (cpu_rst),
		.c1      (c1),
		.ram_ctl (ram_ctl),
		.cyc     (cyc),
		.cpu_ph1 (cpu_ph1),
		.cpu_ph2 (cpu_ph2),
		.ram_cs  (ram_cs)
	);

	video_edge_stage u_edge (
		.clk_114    (clk_114),
		.cpu_rst    (cpu_rst),
		.pix_en     (pix_en),
		.chip_video (chip_video),
		.edge_flags (edge_flags)
	);

	video_encode_stage u_encode (
		.clk_114      (clk_114),
		.cpu_rst      (cpu_rst),
		.pix_en       (pix_en),
		.edge_flags   (edge_flags),
		.scaler_video (scaler_video)
	);

endmodule

// ==== design/video_encode_stage.sv ====
////////////////////////////////////////////////////////////
// video stage 2, builds the scaler output word
// priority is vsync info word, active pixel, then res word
// outputs change on pix_en only
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module video_encode_stage (
	input  logic                       clk_114,
	input  logic                       cpu_rst,
	input  logic                       pix_en,
	input  core_out_pkg::edge_flags_t  edge_flags,
	output core_out_pkg::scaler_video_t scaler_video
);

	import core_out_pkg::*;

	rgb_t info_word;                           // sent with vs pulse
	rgb_t res_word;                            // sent at line end
	scaler_video_t video_nxt;

	////////////////////////////////////////////////////////////
	// side band words
	////////////////////////////////////////////////////////////

	always_comb begin
		info_word = '0;
		info_word[LACE_BIT] = edge_flags.lace;
		info_word[FIELD_BIT] = edge_flags.lace_field;
	end

	always_comb begin
		res_word = '0;
		res_word[RES_LSB +: RES_W] = edge_flags.res;   // 0..3 at 17:16
	end

	////////////////////////////////////////////////////////////
	// priority select
	////////////////////////////////////////////////////////////

	always_comb begin
		video_nxt = '0;                        // default all low
		video_nxt.hs = edge_flags.hs_fall;     // one strobe wide
		if (edge_flags.vs_fall) begin
			// frame start carries interlace info
			video_nxt.vs = 1'b1;
			video_nxt.rgb = info_word;
		end else if (!edge_flags.blank) begin
			video_nxt.rgb = edge_flags.rgb;
			video_nxt.de = 1'b1;
		end else if (edge_flags.hblank_rise) begin
			video_nxt.rgb = res_word;          // first blanked pixel
		end
	end

	always_ff @(posedge clk_114) begin
		if (!cpu_rst)
			scaler_video <= '0;
		else if (pix_en)
			scaler_video <= video_nxt;
	end

	// scaler reads rgb as info word under vs, never as a pixel
	a_de_vs_excl : assert property (@(posedge clk_114) disable iff (!cpu_rst)
		!(scaler_video.de && scaler_video.vs))
		else $error("de and vs high together");

endmodule

// ==== design/video_edge_stage.sv ====
////////////////////////////////////////////////////////////
// video stage 1, samples chipset video on pix_en
// syncs are active low, edges are seen between strobes only
// a sync shorter than one strobe period can be missed
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module video_edge_stage (
	input  logic                     clk_114,
	input  logic                     cpu_rst,
	input  logic                     pix_en,      // pixel strobe
	input  core_out_pkg::chip_video_t chip_video,
	output core_out_pkg::edge_flags_t edge_flags
);

	import core_out_pkg::*;

	logic hs_prev;                             // last sampled hs
	logic vs_prev;                             // last sampled vs
	logic blank_prev;                          // last sampled hblank
	edge_flags_t flags_nxt;

	// edge detect against the previous strobe
	always_comb begin
		flags_nxt = '0;
		flags_nxt.hs_fall = hs_prev & ~chip_video.hs;
		flags_nxt.vs_fall = vs_prev & ~chip_video.vs;
		flags_nxt.hblank_rise = ~blank_prev & chip_video.hblank;
		flags_nxt.blank = chip_video.hblank;
		flags_nxt.lace_field = chip_video.lace & chip_video.field1;
		flags_nxt.lace = chip_video.lace;
		flags_nxt.res = chip_video.res;
		flags_nxt.rgb = chip_video.rgb;    // pixel rides along
	end

	// idle levels, so the first strobe sees no edge
	always_ff @(posedge clk_114) begin
		if (!cpu_rst) begin
			hs_prev <= 1'b1;
			vs_prev <= 1'b1;
			blank_prev <= 1'b0;
		end else if (pix_en) begin
			hs_prev <= chip_video.hs;
			vs_prev <= chip_video.vs;
			blank_prev <= chip_video.hblank;
		end
	end

	always_ff @(posedge clk_114) begin
		if (!cpu_rst)
			edge_flags <= '0;
		else if (pix_en)
			edge_flags <= flags_nxt;           // held between strobes
	end

endmodule

// ==== design/cpu_phase_gen.sv ====
////////////////////////////////////////////////////////////
// cpu bus phase generator, 16 clk_114 cycles per cpu cycle
// c1 must be synchronous to clk_114
// ram_ctl is registered once, ram_cs lags its inputs by one clock
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cpu_phase_gen (
	input  logic                  clk_114,
	input  logic                  cpu_rst,     // sync, active low
	input  logic                  c1,          // chipset phase
	input  core_out_pkg::ram_ctl_t ram_ctl,
	output logic                  cyc,         // memory slot strobe
	output logic                  cpu_ph1,
	output logic                  cpu_ph2,
	output logic                  ram_cs
);

	import core_out_pkg::*;

	div_t div;                                 // phase counter
	logic c1d;                                 // c1 one clock late
	logic c1_rise;
	logic ph_update;                           // low bits at 2
	logic ram_gate;

	assign c1_rise = c1 & ~c1d;
	assign ph_update = (div[1:0] == 2'd2);
	// fast cpu with a ready access in this slot drops the select
	assign ram_gate = ram_ctl.ram_ready & cyc & ram_ctl.cpu_type;

	////////////////////////////////////////////////////////////
	// divider and c1 realignment
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_114) begin
		if (!cpu_rst) begin
			c1d <= 1'b0;
			div <= '0;
		end else begin
			c1d <= c1;
			if (c1_rise)
				div <= DIV_ALIGN;              // snap to chipset phase
			else
				div <= div + div_t'(1);
		end
	end

	////////////////////////////////////////////////////////////
	// slot strobe and phase pulses
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_114) begin
		if (!cpu_rst) begin
			cyc <= 1'b0;
			cpu_ph1 <= 1'b0;
			cpu_ph2 <= 1'b0;
		end else begin
			cyc <= (div[1:0] == 2'd0);         // every 4th clock
			if (ph_update) begin
				// both clear, at most one sets again
				cpu_ph1 <= (div[3:2] == PH1_SLOT);
				cpu_ph2 <= (div[3:2] == PH2_SLOT);
			end
		end
	end

	always_ff @(posedge clk_114) begin
		if (!cpu_rst)
			ram_cs <= 1'b0;
		else
			ram_cs <= ram_ctl.ram_sel & ~ram_gate;
	end

	// cpu sees ph1 and ph2 as two separate phases
	a_ph_exclusive : assert property (@(posedge clk_114) disable iff (!cpu_rst)
		!(cpu_ph1 && cpu_ph2))
		else $error("cpu_ph1 and cpu_ph2 high together");

endmodule

// ==== design/core_out_pkg.sv ====
////////////////////////////////////////////////////////////
// shared types and constants for the core glue logic
// everything lives in the clk_114 domain
// bit positions assume the scaler info word format
////////////////////////////////////////////////////////////

package core_out_pkg;

	localparam int DIV_W = 4;                // phase divider width
	localparam int RGB_W = 24;               // 8 bits per colour
	localparam int RES_W = 2;                // chipset hres code

	typedef logic [DIV_W-1:0] div_t;
	typedef logic [RGB_W-1:0] rgb_t;
	typedef logic [RES_W-1:0] res_t;

	localparam div_t DIV_ALIGN = 4'd3;       // loaded on c1 rising edge
	localparam logic [1:0] PH2_SLOT = 2'd0;  // div[3:2] slot for ph2
	localparam logic [1:0] PH1_SLOT = 2'd2;  // div[3:2] slot for ph1

	// info word and resolution word layout
	localparam int LACE_BIT = 1;
	localparam int FIELD_BIT = 2;            // lace and field1
	localparam int RES_LSB = 16;             // res code at 17:16

	typedef struct packed {
		logic ram_sel;                       // cpu wants ram
		logic ram_ready;                     // ram access done
		logic cpu_type;                      // fast cpu selected
	} ram_ctl_t;

	typedef struct packed {
		logic hs;                            // active low
		logic vs;                            // active low
		logic hblank;
		logic lace;
		logic field1;
		res_t res;
		rgb_t rgb;
	} chip_video_t;

	typedef struct packed {
		logic hs_fall;
		logic vs_fall;
		logic hblank_rise;
		logic blank;                         // sampled hblank
		logic lace_field;                    // field1 and lace
		logic lace;
		res_t res;
		rgb_t rgb;
	} edge_flags_t;

	typedef struct packed {
		rgb_t rgb;
		logic de;
		logic vs;
		logic hs;
	} scaler_video_t;

endpackage
